/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = z80_tb
FILELIST = files.f

SOURCES  = $(shell grep -v '^+' $(FILELIST))
BIN      = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

/* files.f */
z80_pkg.sv
z80_cycle_if.sv
z80_sequencer.sv
z80_mcycle.sv
z80_busreq.sv
z80.sv
z80_assertions.sv
z80_tb.sv

/* z80.sv */
module z80 (
    input  logic        CLK,
    input  logic        reset,
    input  logic        nWAIT,
    input  logic        nBUSRQ,
    input  logic [7:0]  READ_D,

    output logic [15:0] A,
    output logic [7:0]  WRITE_D,
    output logic        nMREQ,
    output logic        nIORQ,
    output logic        nRD,
    output logic        nWR,
    output logic        nM1,
    output logic        nRFSH,
    output logic        nBUSAK
);

    logic stall;  // Bus granted or about to be

    z80_cycle_if cyc ();

    // Fetch, operand and data requests, one at a time
    z80_sequencer sequencer (
        .CLK   (CLK),
        .reset (reset),
        .stall (stall),
        .cyc   (cyc)
    );

    // T-states and bus strobes
    z80_mcycle mcycle (
        .CLK     (CLK),
        .reset   (reset),
        .nWAIT   (nWAIT),
        .READ_D  (READ_D),
        .cyc     (cyc),
        .A       (A),
        .WRITE_D (WRITE_D),
        .nMREQ   (nMREQ),
        .nIORQ   (nIORQ),
        .nRD     (nRD),
        .nWR     (nWR),
        .nM1     (nM1),
        .nRFSH   (nRFSH)
    );

    z80_busreq busreq (
        .CLK         (CLK),
        .reset       (reset),
        .nBUSRQ      (nBUSRQ),
        .mcycle_done (cyc.done),
        .nBUSAK      (nBUSAK),
        .stall       (stall)
    );

endmodule

/* z80_assertions.sv */
module z80_assertions (
    input logic CLK,
    input logic reset,
    input logic nMREQ,
    input logic nIORQ,
    input logic nRD,
    input logic nWR,
    input logic nM1,
    input logic nRFSH,
    input logic nBUSAK
);

    // Read and write strobes are exclusive
    assert property (@(posedge CLK) disable iff (reset) !(!nRD && !nWR))
        else $error("nRD and nWR low in the same clock");

    // Refresh never overlaps the opcode fetch
    assert property (@(posedge CLK) disable iff (reset) !nRFSH |-> nM1)
        else $error("nRFSH low while nM1 is low");

    // Granted bus stays quiet
    assert property (@(posedge CLK) disable iff (reset)
        !nBUSAK |-> (nMREQ && nIORQ && nRD && nWR && nM1 && nRFSH))
        else $error("bus strobe low while nBUSAK is low");

endmodule

bind z80 z80_assertions grant_checks (.*);

/* z80_busreq.sv */
module z80_busreq (
    input  logic CLK,
    input  logic reset,
    input  logic nBUSRQ,
    input  logic mcycle_done,
    output logic nBUSAK,
    output logic stall
);

    logic busrq_q;    // Request as seen on the last edge
    logic grant_now;

    // Grant only on a machine-cycle boundary
    assign grant_now = mcycle_done && busrq_q;

    // Hold the sequencer while the grant is pending or active
    assign stall = grant_now || !nBUSAK;

    // ------------------------------------------------------------------------
    // Request latch and acknowledge
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (reset) begin
            busrq_q <= 1'b0;
            nBUSAK  <= 1'b1;
        end else begin
            busrq_q <= !nBUSRQ;
            if (grant_now) begin
                nBUSAK <= 1'b0;
            end else if (!busrq_q && !nBUSAK) begin
                nBUSAK <= 1'b1;  // Release one clock after the request drops
            end
        end
    end

endmodule

/* z80_cycle_if.sv */
interface z80_cycle_if;

    logic                             start;  // One-clock request pulse
    logic [z80_pkg::cycle_kind_w-1:0] kind;
    logic [15:0]                      addr;
    logic [7:0]                       wdata;
    logic [7:0]                       rdata;  // Valid while done is high
    logic                             done;   // Last T-state of the cycle

    // Sequencer side
    // kind, addr and wdata stay stable from start until done
    modport seq (
        output start,
        output kind,
        output addr,
        output wdata,
        input  rdata,
        input  done
    );

    // Cycle engine side
    modport eng (
        input  start,
        input  kind,
        input  addr,
        input  wdata,
        output rdata,
        output done
    );

endinterface

/* z80_mcycle.sv */
module z80_mcycle (
    input  logic        CLK,
    input  logic        reset,
    input  logic        nWAIT,
    input  logic [7:0]  READ_D,
    z80_cycle_if.eng    cyc,
    output logic [15:0] A,
    output logic [7:0]  WRITE_D,
    output logic        nMREQ,
    output logic        nIORQ,
    output logic        nRD,
    output logic        nWR,
    output logic        nM1,
    output logic        nRFSH
);

    logic [2:0]  tstate;       // 0 when idle, else base T-state 1..N
    logic [2:0]  tstate_next;
    logic [2:0]  base;
    logic [2:0]  sample_t;     // T-state where nWAIT is sampled
    logic        is_m1;
    logic        is_io;
    logic [6:0]  r;            // Refresh counter
    logic [7:0]  rdata_q;
    logic [15:0] addr_next;
    logic        mreq_next;
    logic        iorq_next;
    logic        rd_next;
    logic        wr_next;
    logic        m1_next;
    logic        rfsh_next;

    assign is_m1 = (cyc.kind == z80_pkg::cycle_m1);
    assign is_io = (cyc.kind == z80_pkg::cycle_io_rd) || (cyc.kind == z80_pkg::cycle_io_wr);

    assign base     = is_m1 ? z80_pkg::tstates_m1 :
                      is_io ? z80_pkg::tstates_io : z80_pkg::tstates_mem;
    assign sample_t = is_io ? 3'd3 : 3'd2;  // I/O samples in its automatic wait

    assign cyc.done = (tstate == base);

    // Opcode byte is held from T2, other reads come straight off the bus in T3
    assign cyc.rdata = is_m1 ? rdata_q : READ_D;

    // ------------------------------------------------------------------------
    // T-state counter
    // ------------------------------------------------------------------------
    always_comb begin
        tstate_next = tstate;
        if (tstate == 3'd0) begin
            if (cyc.start) begin
                tstate_next = 3'd1;
            end
        end else if (cyc.done) begin
            tstate_next = 3'd0;
        end else if (tstate != sample_t || nWAIT) begin
            tstate_next = tstate + 3'd1;
        end
        // Low nWAIT at the sample point holds the count for one Tw
    end

    // ------------------------------------------------------------------------
    // Strobes and address for the coming T-state
    // ------------------------------------------------------------------------
    always_comb begin
        mreq_next = 1'b0;
        iorq_next = 1'b0;
        rd_next   = 1'b0;
        wr_next   = 1'b0;
        m1_next   = 1'b0;
        rfsh_next = 1'b0;
        addr_next = A;  // Idle bus keeps the last address
        if (tstate_next != 3'd0) begin
            addr_next = cyc.addr;
            case (cyc.kind)
                z80_pkg::cycle_m1: begin
                    if (tstate_next <= 3'd2) begin  // T1, T2 and Tw
                        m1_next   = 1'b1;
                        mreq_next = 1'b1;
                        rd_next   = 1'b1;
                    end else begin                  // Refresh in T3 and T4
                        rfsh_next = 1'b1;
                        mreq_next = (tstate_next == 3'd3);
                        addr_next = {9'd0, r};
                    end
                end
                z80_pkg::cycle_mem_rd: begin
                    mreq_next = 1'b1;
                    rd_next   = 1'b1;
                end
                z80_pkg::cycle_mem_wr: begin
                    mreq_next = 1'b1;
                    wr_next   = (tstate_next >= 3'd2);
                end
                z80_pkg::cycle_io_rd: begin
                    iorq_next = (tstate_next >= 3'd2);
                    rd_next   = (tstate_next >= 3'd2);
                end
                z80_pkg::cycle_io_wr: begin
                    iorq_next = (tstate_next >= 3'd2);
                    wr_next   = (tstate_next >= 3'd2);
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            tstate <= 3'd0;
            r      <= 7'd0;
            nMREQ  <= 1'b1;
            nIORQ  <= 1'b1;
            nRD    <= 1'b1;
            nWR    <= 1'b1;
            nM1    <= 1'b1;
            nRFSH  <= 1'b1;
        end else begin
            tstate <= tstate_next;
            nMREQ  <= !mreq_next;
            nIORQ  <= !iorq_next;
            nRD    <= !rd_next;
            nWR    <= !wr_next;
            nM1    <= !m1_next;
            nRFSH  <= !rfsh_next;
            if (cyc.done && is_m1) begin
                r <= r + 7'd1;  // Advance after each refresh
            end
        end
    end

    // Bus payload
    always_ff @(posedge CLK) begin
        A <= addr_next;
        if (cyc.start) begin
            WRITE_D <= cyc.wdata;
        end
        if (is_m1 && tstate == sample_t && nWAIT) begin
            rdata_q <= READ_D;  // End of the last T2/Tw
        end
    end

endmodule

/* z80_pkg.sv */
package z80_pkg;

    // ------------------------------------------------------------------------
    // Machine-cycle kinds
    // ------------------------------------------------------------------------
    localparam int cycle_kind_w = 3;

    localparam logic [cycle_kind_w-1:0] cycle_none   = 3'd0;
    localparam logic [cycle_kind_w-1:0] cycle_m1     = 3'd1;  // Opcode fetch with refresh
    localparam logic [cycle_kind_w-1:0] cycle_mem_rd = 3'd2;
    localparam logic [cycle_kind_w-1:0] cycle_mem_wr = 3'd3;
    localparam logic [cycle_kind_w-1:0] cycle_io_rd  = 3'd4;
    localparam logic [cycle_kind_w-1:0] cycle_io_wr  = 3'd5;

    // Base T-states per cycle, before any inserted Tw
    localparam logic [2:0] tstates_m1  = 3'd4;
    localparam logic [2:0] tstates_mem = 3'd3;
    localparam logic [2:0] tstates_io  = 3'd4;  // Includes the automatic wait

    // ------------------------------------------------------------------------
    // Supported opcodes
    // ------------------------------------------------------------------------
    localparam logic [7:0] op_nop     = 8'h00;
    localparam logic [7:0] op_ld_a_n  = 8'h3E;
    localparam logic [7:0] op_ld_a_nn = 8'h3A;
    localparam logic [7:0] op_ld_nn_a = 8'h32;
    localparam logic [7:0] op_out_n_a = 8'hD3;
    localparam logic [7:0] op_in_a_n  = 8'hDB;
    localparam logic [7:0] op_jp_nn   = 8'hC3;
    localparam logic [7:0] op_halt    = 8'h76;

    // Sequencer steps
    localparam int seq_state_w = 3;

    localparam logic [seq_state_w-1:0] st_fetch  = 3'd0;
    localparam logic [seq_state_w-1:0] st_op_lo  = 3'd1;
    localparam logic [seq_state_w-1:0] st_op_hi  = 3'd2;
    localparam logic [seq_state_w-1:0] st_exec   = 3'd3;
    localparam logic [seq_state_w-1:0] st_halt   = 3'd4;

    // ------------------------------------------------------------------------
    // Fetched byte, either raw or split into the x/y/z decode fields
    // ------------------------------------------------------------------------
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [1:0] x;  // Opcode quadrant
            logic [2:0] y;
            logic [2:0] z;
        } f;
    } opcode_t;

endpackage

/* z80_sequencer.sv */
module z80_sequencer (
    input  logic      CLK,
    input  logic      reset,
    input  logic      stall,
    z80_cycle_if.seq  cyc
);

    logic [z80_pkg::seq_state_w-1:0] state;
    logic [z80_pkg::seq_state_w-1:0] after_fetch;  // Step that follows the opcode fetch
    logic [15:0]                     pc;
    logic [7:0]                      acc;
    logic [15:0]                     operand;
    z80_pkg::opcode_t                opcode;       // Opcode of the current instruction
    z80_pkg::opcode_t                fetched;      // Byte returned by an M1 cycle
    logic                            busy;         // Cycle issued and not yet done

    assign fetched = cyc.rdata;

    // Issue as soon as the previous cycle is done and the bus is ours
    assign cyc.start = !busy && !stall;

    // ------------------------------------------------------------------------
    // Opcode classification, by quadrant first and then by raw value
    // ------------------------------------------------------------------------
    always_comb begin
        after_fetch = z80_pkg::st_fetch;  // Anything unknown runs as NOP
        case (fetched.f.x)
            2'd0: begin  // Immediate and direct loads
                if (fetched.raw == z80_pkg::op_ld_a_n ||
                    fetched.raw == z80_pkg::op_ld_a_nn ||
                    fetched.raw == z80_pkg::op_ld_nn_a) begin
                    after_fetch = z80_pkg::st_op_lo;
                end
            end
            2'd1: begin  // LD r,r' block, only HALT lives here
                if (fetched.f.y == 3'd6 && fetched.f.z == 3'd6 &&
                    fetched.raw == z80_pkg::op_halt) begin
                    after_fetch = z80_pkg::st_halt;
                end
            end
            2'd3: begin  // Port and jump group
                if (fetched.raw == z80_pkg::op_out_n_a ||
                    fetched.raw == z80_pkg::op_in_a_n ||
                    fetched.raw == z80_pkg::op_jp_nn) begin
                    after_fetch = z80_pkg::st_op_lo;
                end
            end
            default: ;
        endcase
    end

    // ------------------------------------------------------------------------
    // Cycle request for the current step
    // ------------------------------------------------------------------------
    always_comb begin
        cyc.kind  = z80_pkg::cycle_m1;  // Fetch and halted refetch
        cyc.addr  = pc;
        cyc.wdata = acc;
        case (state)
            z80_pkg::st_op_lo,
            z80_pkg::st_op_hi: cyc.kind = z80_pkg::cycle_mem_rd;
            z80_pkg::st_exec: begin
                case (opcode.raw)
                    z80_pkg::op_ld_a_nn: begin
                        cyc.kind = z80_pkg::cycle_mem_rd;
                        cyc.addr = operand;
                    end
                    z80_pkg::op_ld_nn_a: begin
                        cyc.kind = z80_pkg::cycle_mem_wr;
                        cyc.addr = operand;
                    end
                    z80_pkg::op_out_n_a: begin
                        cyc.kind = z80_pkg::cycle_io_wr;
                        cyc.addr = {acc, operand[7:0]};  // A on the upper byte
                    end
                    z80_pkg::op_in_a_n: begin
                        cyc.kind = z80_pkg::cycle_io_rd;
                        cyc.addr = {acc, operand[7:0]};
                    end
                    default: cyc.kind = z80_pkg::cycle_none;
                endcase
            end
            default: ;
        endcase
    end

    // ------------------------------------------------------------------------
    // Step, PC and accumulator updates at the end of each cycle
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (reset) begin
            state <= z80_pkg::st_fetch;
            pc    <= 16'd0;
            acc   <= 8'd0;
            busy  <= 1'b0;
        end else begin
            if (cyc.start) begin
                busy <= 1'b1;
            end
            if (cyc.done) begin
                busy <= 1'b0;
                case (state)
                    z80_pkg::st_fetch: begin
                        pc    <= pc + 16'd1;
                        state <= after_fetch;
                    end
                    z80_pkg::st_op_lo: begin
                        pc <= pc + 16'd1;
                        if (opcode.raw == z80_pkg::op_ld_a_n) begin
                            acc   <= cyc.rdata;
                            state <= z80_pkg::st_fetch;
                        end else if (opcode.raw == z80_pkg::op_out_n_a ||
                                     opcode.raw == z80_pkg::op_in_a_n) begin
                            state <= z80_pkg::st_exec;
                        end else begin
                            state <= z80_pkg::st_op_hi;  // 16-bit operand
                        end
                    end
                    z80_pkg::st_op_hi: begin
                        if (opcode.raw == z80_pkg::op_jp_nn) begin
                            pc    <= {cyc.rdata, operand[7:0]};
                            state <= z80_pkg::st_fetch;
                        end else begin
                            pc    <= pc + 16'd1;
                            state <= z80_pkg::st_exec;
                        end
                    end
                    z80_pkg::st_exec: begin
                        if (opcode.raw == z80_pkg::op_ld_a_nn ||
                            opcode.raw == z80_pkg::op_in_a_n) begin
                            acc <= cyc.rdata;
                        end
                        state <= z80_pkg::st_fetch;
                    end
                    default: ;  // Halted, PC stays on HALT address + 1
                endcase
            end
        end
    end

    // Instruction payload
    always_ff @(posedge CLK) begin
        if (cyc.done) begin
            case (state)
                z80_pkg::st_fetch: opcode        <= fetched;
                z80_pkg::st_op_lo: operand[7:0]  <= cyc.rdata;
                z80_pkg::st_op_hi: operand[15:8] <= cyc.rdata;
                default: ;
            endcase
        end
    end

endmodule

/* z80_tb.sv */
module z80_tb;

    localparam int halt_fetches = 6;

    logic        CLK = 1'b0;
    logic        reset;
    logic        nWAIT;
    logic        nBUSRQ;
    logic [7:0]  READ_D;
    logic [15:0] A;
    logic [7:0]  WRITE_D;
    logic        nMREQ, nIORQ, nRD, nWR, nM1, nRFSH, nBUSAK;

    logic [7:0]  mem     [0:65535];  // Bus-side memory
    logic [7:0]  ref_mem [0:65535];  // Reference model's own copy

    // Expected cycles, one entry per machine cycle
    logic [z80_pkg::cycle_kind_w-1:0] exp_kind [$];
    logic [15:0]                      exp_addr [$];
    logic [7:0]                       exp_data [$];
    int                               exp_m1   [$];

    int seed, errors, checks, cycles, halt_start, halt_seen, err_at_halt, err_after_reset;
    int grants, grant_errs, clk_count, burst, len, waits, timeout;
    logic                             in_cyc, act, act_q, busak_q;
    logic [1:0]                       rq_q;
    logic [z80_pkg::cycle_kind_w-1:0] cur_kind;
    logic [15:0]                      cur_addr, cur_rfsh;
    logic [7:0]                       cur_data;

    z80 UUT (.*);

    always #20 CLK = ~CLK;

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------
    task automatic check_kind(input logic [z80_pkg::cycle_kind_w-1:0] got, exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s kind %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input logic [15:0] got, exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_data(input logic [7:0] got, exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_length(input int got, exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED %0t: %s %0d T-states, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_grant(input logic got, exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0t: %s %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic push_cycle(input logic [2:0] kind, input logic [15:0] addr,
                              input logic [7:0] data, input int m1);
        exp_kind.push_back(kind);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_m1.push_back(m1);
    endtask

    // Weighted random program with data accesses in page 80h
    task automatic gen_program();
        logic [15:0] a;
        logic [15:0] target;
        logic [7:0]  b;
        int          r;
        a = 16'd0;
        while (a < 16'h0180) begin
            r = $random(seed) & 15;
            b = 8'($random(seed));
            case (r)
                0, 1: begin
                    mem[a] = z80_pkg::op_nop;
                    a = a + 16'd1;
                end
                2, 3, 6, 7, 8, 9: begin
                    mem[a] = (r < 4) ? z80_pkg::op_ld_a_n :
                             (r < 8) ? z80_pkg::op_out_n_a : z80_pkg::op_in_a_n;
                    mem[a + 16'd1] = b;
                    a = a + 16'd2;
                end
                4, 5: begin
                    mem[a] = (r == 4) ? z80_pkg::op_ld_a_nn : z80_pkg::op_ld_nn_a;
                    mem[a + 16'd1] = b;
                    mem[a + 16'd2] = 8'h80;
                    a = a + 16'd3;
                end
                10, 11: begin  // Forward jump over a few HALT bytes
                    target = a + 16'd3 + 16'(b & 8'd3);
                    mem[a] = z80_pkg::op_jp_nn;
                    mem[a + 16'd1] = target[7:0];
                    mem[a + 16'd2] = target[15:8];
                    for (logic [15:0] g = a + 16'd3; g < target; g++) begin
                        mem[g] = z80_pkg::op_halt;
                    end
                    a = target;
                end
                default: begin  // Anything unsupported runs as NOP
                    if (b == z80_pkg::op_ld_a_n || b == z80_pkg::op_ld_a_nn ||
                        b == z80_pkg::op_ld_nn_a || b == z80_pkg::op_out_n_a ||
                        b == z80_pkg::op_in_a_n || b == z80_pkg::op_jp_nn ||
                        b == z80_pkg::op_halt) b = z80_pkg::op_nop;
                    mem[a] = b;
                    a = a + 16'd1;
                end
            endcase
        end
        mem[a] = z80_pkg::op_halt;
    endtask

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    task automatic build_expected();
        logic [15:0] pc;
        logic [15:0] nn;
        logic [7:0]  acc;
        logic [7:0]  op;
        int          m1;
        int          steps;
        pc = 16'd0;
        acc = 8'd0;
        op = 8'd0;
        m1 = 0;
        steps = 0;
        while (op != z80_pkg::op_halt && steps < 5000) begin
            push_cycle(z80_pkg::cycle_m1, pc, acc, m1);
            m1++;
            steps++;
            op = ref_mem[pc];
            pc = pc + 16'd1;
            case (op)
                z80_pkg::op_ld_a_n: begin
                    push_cycle(z80_pkg::cycle_mem_rd, pc, acc, 0);
                    acc = ref_mem[pc];
                    pc = pc + 16'd1;
                end
                z80_pkg::op_out_n_a, z80_pkg::op_in_a_n: begin
                    push_cycle(z80_pkg::cycle_mem_rd, pc, acc, 0);
                    nn = {acc, ref_mem[pc]};  // Port address carries A on top
                    pc = pc + 16'd1;
                    if (op == z80_pkg::op_out_n_a) begin
                        push_cycle(z80_pkg::cycle_io_wr, nn, acc, 0);
                    end else begin
                        push_cycle(z80_pkg::cycle_io_rd, nn, acc, 0);
                        acc = nn[15:8] ^ nn[7:0];
                    end
                end
                z80_pkg::op_ld_a_nn, z80_pkg::op_ld_nn_a, z80_pkg::op_jp_nn: begin
                    push_cycle(z80_pkg::cycle_mem_rd, pc, acc, 0);
                    push_cycle(z80_pkg::cycle_mem_rd, pc + 16'd1, acc, 0);
                    nn = {ref_mem[pc + 16'd1], ref_mem[pc]};
                    pc = pc + 16'd2;
                    if (op == z80_pkg::op_jp_nn) begin
                        pc = nn;
                    end else if (op == z80_pkg::op_ld_a_nn) begin
                        push_cycle(z80_pkg::cycle_mem_rd, nn, acc, 0);
                        acc = ref_mem[nn];
                    end else begin
                        push_cycle(z80_pkg::cycle_mem_wr, nn, acc, 0);
                        ref_mem[nn] = acc;
                    end
                end
                default: ;
            endcase
        end
        halt_start = exp_kind.size();
        repeat (halt_fetches) begin  // Halted refetch stays on HALT + 1
            push_cycle(z80_pkg::cycle_m1, pc, acc, m1);
            m1++;
        end
    endtask

    task automatic end_cycle();
        int base;
        if (exp_kind.size() > 0) begin
            if (cycles == halt_start) err_at_halt = errors;
            base = (exp_kind[0] == z80_pkg::cycle_m1) ? int'(z80_pkg::tstates_m1) :
                   (exp_kind[0] >= z80_pkg::cycle_io_rd) ? int'(z80_pkg::tstates_io) :
                   int'(z80_pkg::tstates_mem);
            check_kind(cur_kind, exp_kind[0], "cycle");
            check_addr(cur_addr, exp_addr[0], "address");
            if (exp_kind[0] == z80_pkg::cycle_mem_wr || exp_kind[0] == z80_pkg::cycle_io_wr)
                check_data(cur_data, exp_data[0], "write data");
            if (exp_kind[0] == z80_pkg::cycle_m1)
                check_addr(cur_rfsh, 16'(exp_m1[0] % 128), "refresh address");
            check_length(len, base + waits, "cycle length");
            if (cycles >= halt_start) halt_seen++;
            cycles++;
            void'(exp_kind.pop_front());
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
            void'(exp_m1.pop_front());
        end
    endtask

    // ------------------------------------------------------------------------
    // Bus-side models, driven after the rising edge
    // ------------------------------------------------------------------------
    always @(posedge CLK) begin
        #5;
        clk_count++;
        if (!nMREQ && !nWR) mem[A] = WRITE_D;
        READ_D = !nIORQ ? (A[7:0] ^ A[15:8]) : mem[A];  // I/O answers low ^ high
        nWAIT = 1'b1;
        if (!nMREQ || !nIORQ || !nRD || !nWR) nWAIT = (($random(seed) & 3) != 0);
        if (burst > 0) begin
            burst--;
        end else if (clk_count > 10 && ($random(seed) & 31) == 0) begin
            burst = 2 + ($random(seed) & 7);
        end
        nBUSRQ = (burst == 0);
    end

    // Monitor samples mid-clock
    always @(negedge CLK) begin
        if (!reset) begin
            act = !nMREQ || !nIORQ || !nRD || !nWR || !nM1 || !nRFSH;
            if (!nBUSAK && act) begin
                grant_errs++;
                $display("A bus strobe was active at %0t while the bus was granted", $time);
            end
            if (!nBUSAK && busak_q) begin
                grants++;
                if (!act_q || rq_q[1]) begin
                    grant_errs++;
                    $display("nBUSAK fell at %0t without a finished cycle under request", $time);
                end
            end
            if (act && !in_cyc) begin
                in_cyc = 1'b1;
                len = !nIORQ ? 2 : 1;  // I/O shows no strobe in T1
                waits = 0;
                cur_addr = A;
                cur_data = WRITE_D;
                cur_kind = !nM1   ? z80_pkg::cycle_m1 :
                           !nMREQ ? (!nRD ? z80_pkg::cycle_mem_rd : z80_pkg::cycle_mem_wr) :
                                    (!nRD ? z80_pkg::cycle_io_rd : z80_pkg::cycle_io_wr);
            end else if (act) begin
                len++;
            end
            if (!nRFSH) cur_rfsh = A;
            // nWAIT sample points are T2 (T3 for I/O) and each Tw
            if (act && !nWAIT && len == ((cur_kind >= z80_pkg::cycle_io_rd) ? 3 : 2) + waits)
                waits++;
            if (!act && in_cyc) begin
                in_cyc = 1'b0;
                // Request seen in the clock before the last T-state decides the grant
                check_grant(nBUSAK, rq_q[1], "nBUSAK after cycle end");
                end_cycle();
            end
            busak_q = nBUSAK;
            act_q = act;
            rq_q = {rq_q[0], nBUSRQ};
        end
    end

    initial begin
        seed = 37;
        reset = 1'b1;
        nWAIT = 1'b1;
        nBUSRQ = 1'b1;
        READ_D = 8'd0;
        in_cyc = 1'b0;
        act_q = 1'b0;
        busak_q = 1'b1;
        rq_q = 2'b11;
        for (int i = 0; i < 65536; i++) begin
            logic [15:0] ai;
            ai = i[15:0];
            mem[ai] = ai[15:8] ^ {ai[6:0], ai[7]} ^ 8'h5A;
        end
        gen_program();
        for (int i = 0; i < 65536; i++) ref_mem[i[15:0]] = mem[i[15:0]];
        build_expected();

        repeat (4) @(posedge CLK);
        @(negedge CLK);
        check_data({nMREQ, nIORQ, nRD, nWR, nM1, nRFSH, nBUSAK, 1'b1}, 8'hFF, "strobes in reset");
        @(posedge CLK);
        #5 reset = 1'b0;
        err_after_reset = errors;
        err_at_halt = errors;
        $display("reset state: %0d errors", errors);

        timeout = 0;
        while (exp_kind.size() > 0 && timeout < 40000) begin
            @(posedge CLK);
            timeout++;
        end
        if (exp_kind.size() > 0) begin
            errors++;
            $display("Timed out with %0d expected bus cycles never seen", exp_kind.size());
        end
        $display("cycle trace: %0d cycles, %0d errors", halt_start, err_at_halt - err_after_reset);
        $display("halt refetch: %0d fetches, %0d errors", halt_seen, errors - err_at_halt);
        $display("bus grants: %0d grants, %0d errors", grants, grant_errs);
        $display("tests 4, checks %0d, errors %0d", checks, errors + grant_errs);
        if (errors == 0 && grant_errs == 0 && halt_seen == halt_fetches) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
